// ==== Makefile ====
# verilator build and run of the dual biu testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_biu_dual_ahb -o tb_sim
	./obj_dir/tb_sim

clean:
	rm -rf obj_dir

// ==== ahb_master_arbiter.sv ====
//////////////////////////////
// two-master ahb-lite arbiter
// grant moves at burst boundaries, data master first
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ahb_master_arbiter (
  input  logic                         HCLK_i,
  input  logic                         HRESETn_i,
  // instruction master
  input  logic [biu_ahb_pkg::PLEN-1:0] ihaddr_i,
  input  logic                         ihwrite_i,
  input  logic [2:0]                   ihsize_i,
  input  logic [2:0]                   ihburst_i,
  input  logic [3:0]                   ihprot_i,
  input  logic [1:0]                   ihtrans_i,
  input  logic                         ihmastlock_i,
  input  logic [biu_ahb_pkg::XLEN-1:0] ihwdata_i,
  output logic                         ihready_o,
  output logic                         ihresp_o,
  // data master
  input  logic [biu_ahb_pkg::PLEN-1:0] dhaddr_i,
  input  logic                         dhwrite_i,
  input  logic [2:0]                   dhsize_i,
  input  logic [2:0]                   dhburst_i,
  input  logic [3:0]                   dhprot_i,
  input  logic [1:0]                   dhtrans_i,
  input  logic                         dhmastlock_i,
  input  logic [biu_ahb_pkg::XLEN-1:0] dhwdata_i,
  output logic                         dhready_o,
  output logic                         dhresp_o,
  // shared bus
  output logic [biu_ahb_pkg::PLEN-1:0] haddr_o,
  output logic                         hwrite_o,
  output logic [2:0]                   hsize_o,
  output logic [2:0]                   hburst_o,
  output logic [3:0]                   hprot_o,
  output logic [1:0]                   htrans_o,
  output logic                         hmastlock_o,
  output logic [biu_ahb_pkg::XLEN-1:0] hwdata_o,
  input  logic                         hready_i,
  input  logic                         hresp_i
);

  logic [biu_ahb_pkg::NUM_MASTERS-1:0] req;  // non-idle address phase per master
  logic grant;      // address phase owner
  logic owner;      // data phase owner
  logic nxt_grant;
  logic gnt_lock;   // granted master holds the bus
  logic gnt_dbus;
  logic own_dbus;

  assign req[biu_ahb_pkg::MST_IBUS] = (ihtrans_i != biu_ahb_pkg::HTRANS_IDLE);
  assign req[biu_ahb_pkg::MST_DBUS] = (dhtrans_i != biu_ahb_pkg::HTRANS_IDLE);

  assign gnt_dbus = (grant == biu_ahb_pkg::MST_DBUS);
  assign own_dbus = (owner == biu_ahb_pkg::MST_DBUS);
  assign gnt_lock = gnt_dbus ? dhmastlock_i : ihmastlock_i;

  //////////////////////////////
  // grant

  // only once the granted master is idle and unlocked
  always_comb begin
    nxt_grant = grant;
    if (!req[grant] && !gnt_lock) begin
      if (req[biu_ahb_pkg::MST_DBUS]) begin
        nxt_grant = biu_ahb_pkg::MST_DBUS;  // data side wins
      end else if (req[biu_ahb_pkg::MST_IBUS]) begin
        nxt_grant = biu_ahb_pkg::MST_IBUS;
      end
    end
  end

  always_ff @(posedge HCLK_i or negedge HRESETn_i) begin
    if (!HRESETn_i) begin
      grant <= biu_ahb_pkg::MST_DBUS;
      owner <= biu_ahb_pkg::MST_DBUS;
    end else if (hready_i) begin
      grant <= nxt_grant;
      owner <= grant;  // accepted address phase becomes data phase
    end
  end

  //////////////////////////////
  // muxes

  assign haddr_o     = gnt_dbus ? dhaddr_i     : ihaddr_i;
  assign hwrite_o    = gnt_dbus ? dhwrite_i    : ihwrite_i;
  assign hsize_o     = gnt_dbus ? dhsize_i     : ihsize_i;
  assign hburst_o    = gnt_dbus ? dhburst_i    : ihburst_i;
  assign hprot_o     = gnt_dbus ? dhprot_i     : ihprot_i;
  assign htrans_o    = gnt_dbus ? dhtrans_i    : ihtrans_i;
  assign hmastlock_o = gnt_lock;
  assign hwdata_o    = own_dbus ? dhwdata_i : ihwdata_i;  // follows data phase

  // a waiting master sees a wait state
  assign ihready_o = (!gnt_dbus || !req[biu_ahb_pkg::MST_IBUS]) ? hready_i : 1'b0;
  assign dhready_o = (gnt_dbus || !req[biu_ahb_pkg::MST_DBUS]) ? hready_i : 1'b0;

  assign ihresp_o = own_dbus ? biu_ahb_pkg::HRESP_OKAY : hresp_i;
  assign dhresp_o = own_dbus ? hresp_i : biu_ahb_pkg::HRESP_OKAY;

endmodule

`default_nettype wire

// ==== ahb_mem_slave.sv ====
//////////////////////////////
// ahb-lite memory slave for the testbench
// 256 words, one wait state on every other transfer,
// two cycle error response from 0x800 up
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ahb_mem_slave (
  input  logic        HCLK_i,
  input  logic        HRESETn_i,
  input  logic [31:0] haddr_i,
  input  logic        hwrite_i,
  input  logic [1:0]  htrans_i,
  input  logic [31:0] hwdata_i,
  output logic [31:0] hrdata_o,
  output logic        hready_o,
  output logic        hresp_o
);

  logic [31:0] mem [256];
  logic [7:0]  dp_idx;    // word index of the data phase
  logic        dp_act;    // data phase in progress
  logic        dp_we;
  logic        dp_fault;  // fault region hit
  logic        dp_wait;   // wait state still owed
  logic        err2;      // second error cycle
  logic        toggle;    // alternates per transfer

  assign hrdata_o = mem[dp_idx];
  assign hresp_o  = dp_act & dp_fault;
  assign hready_o = !dp_act || (dp_fault ? err2 : !dp_wait);

  always_ff @(posedge HCLK_i or negedge HRESETn_i) begin
    if (!HRESETn_i) begin
      dp_idx   <= 8'd0;
      dp_act   <= 1'b0;
      dp_we    <= 1'b0;
      dp_fault <= 1'b0;
      dp_wait  <= 1'b0;
      err2     <= 1'b0;
      toggle   <= 1'b0;
    end else if (dp_act && dp_fault && !err2) begin
      err2 <= 1'b1;  // hready rises with hresp still error
    end else if (dp_act && dp_wait) begin
      dp_wait <= 1'b0;
    end else begin
      if (dp_act && dp_we && !dp_fault) begin
        mem[dp_idx] <= hwdata_i;  // write at end of data phase
      end
      err2     <= 1'b0;
      dp_act   <= htrans_i[1];  // nonseq or seq
      dp_we    <= hwrite_i;
      dp_idx   <= haddr_i[9:2];
      dp_fault <= (haddr_i >= 32'h800);
      dp_wait  <= toggle & htrans_i[1] & (haddr_i < 32'h800);
      if (htrans_i[1]) begin
        toggle <= ~toggle;
      end
    end
  end

endmodule

`default_nettype wire

// ==== biu_ahb_master.sv ====
//////////////////////////////
// biu to ahb-lite master
// strobes become address phases, bursts are counted
// and stepped, an error response aborts the burst
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module biu_ahb_master (
  input  logic                         HCLK_i,
  input  logic                         HRESETn_i,
  // core side
  input  logic                         biu_stb_i,
  output logic                         biu_stb_ack_o,  // request taken
  output logic                         biu_d_ack_o,    // write data taken
  input  logic [biu_ahb_pkg::PLEN-1:0] biu_adri_i,
  output logic [biu_ahb_pkg::PLEN-1:0] biu_adro_o,     // address of current data phase
  input  logic [2:0]                   biu_size_i,
  input  logic [2:0]                   biu_type_i,
  input  logic [2:0]                   biu_prot_i,
  input  logic                         biu_lock_i,
  input  logic                         biu_we_i,
  input  logic [biu_ahb_pkg::XLEN-1:0] biu_d_i,
  output logic [biu_ahb_pkg::XLEN-1:0] biu_q_o,
  output logic                         biu_ack_o,      // beat done
  output logic                         biu_err_o,      // request aborted
  // ahb-lite side, towards the arbiter
  output logic [biu_ahb_pkg::PLEN-1:0] m_haddr_o,
  output logic                         m_hwrite_o,
  output logic [2:0]                   m_hsize_o,
  output logic [2:0]                   m_hburst_o,
  output logic [3:0]                   m_hprot_o,
  output logic [1:0]                   m_htrans_o,
  output logic                         m_hmastlock_o,
  output logic [biu_ahb_pkg::XLEN-1:0] m_hwdata_o,
  input  logic                         m_hready_i,
  input  logic                         m_hresp_i,
  input  logic [biu_ahb_pkg::XLEN-1:0] hrdata_i
);

  //////////////////////////////
  // conversions

  function automatic logic [2:0] size2hsize(input logic [2:0] size);
    case (size)
      biu_ahb_pkg::BIU_BYTE:  return biu_ahb_pkg::HSIZE_BYTE;
      biu_ahb_pkg::BIU_HWORD: return biu_ahb_pkg::HSIZE_HWORD;
      default:                return biu_ahb_pkg::HSIZE_WORD;  // nothing wider than a word
    endcase
  endfunction

  // beats in the burst minus one
  function automatic logic [3:0] type2cnt(input logic [2:0] btype);
    case (btype)
      biu_ahb_pkg::BIU_WRAP4,  biu_ahb_pkg::BIU_INCR4:  return 4'd3;
      biu_ahb_pkg::BIU_WRAP8,  biu_ahb_pkg::BIU_INCR8:  return 4'd7;
      biu_ahb_pkg::BIU_WRAP16, biu_ahb_pkg::BIU_INCR16: return 4'd15;
      default:                                          return 4'd0;  // single, incr
    endcase
  endfunction

  function automatic logic [2:0] type2hburst(input logic [2:0] btype);
    case (btype)
      biu_ahb_pkg::BIU_INCR:   return biu_ahb_pkg::HBURST_INCR;
      biu_ahb_pkg::BIU_WRAP4:  return biu_ahb_pkg::HBURST_WRAP4;
      biu_ahb_pkg::BIU_INCR4:  return biu_ahb_pkg::HBURST_INCR4;
      biu_ahb_pkg::BIU_WRAP8:  return biu_ahb_pkg::HBURST_WRAP8;
      biu_ahb_pkg::BIU_INCR8:  return biu_ahb_pkg::HBURST_INCR8;
      biu_ahb_pkg::BIU_WRAP16: return biu_ahb_pkg::HBURST_WRAP16;
      biu_ahb_pkg::BIU_INCR16: return biu_ahb_pkg::HBURST_INCR16;
      default:                 return biu_ahb_pkg::HBURST_SINGLE;
    endcase
  endfunction

  // non-bufferable always
  function automatic logic [3:0] prot2hprot(input logic [2:0] prot);
    logic [3:0] hp;
    hp = 4'b0000;
    if (|(prot & biu_ahb_pkg::PROT_DATA)) hp = hp | biu_ahb_pkg::HPROT_DATA;
    if (|(prot & biu_ahb_pkg::PROT_PRIVILEGED)) hp = hp | biu_ahb_pkg::HPROT_PRIVILEGED;
    if (|(prot & biu_ahb_pkg::PROT_CACHEABLE)) hp = hp | biu_ahb_pkg::HPROT_CACHEABLE;
    return hp;
  endfunction

  // word step, wrap keeps the upper bits of the block
  function automatic logic [biu_ahb_pkg::PLEN-1:0] nxt_addr(
    input logic [biu_ahb_pkg::PLEN-1:0] addr,
    input logic [2:0]                   hburst
  );
    logic [biu_ahb_pkg::PLEN-1:0] lin;
    lin      = addr + 'h4;
    lin[1:0] = 2'b00;  // word aligned
    case (hburst)
      biu_ahb_pkg::HBURST_WRAP4:  return {addr[biu_ahb_pkg::PLEN-1:4], lin[3:0]};  // 16 bytes
      biu_ahb_pkg::HBURST_WRAP8:  return {addr[biu_ahb_pkg::PLEN-1:5], lin[4:0]};  // 32 bytes
      biu_ahb_pkg::HBURST_WRAP16: return {addr[biu_ahb_pkg::PLEN-1:6], lin[5:0]};  // 64 bytes
      default:                    return lin;
    endcase
  endfunction

  //////////////////////////////
  // control

  logic [3:0] burst_cnt;   // beats still to issue
  logic       burst_idle;  // last beat issued or no burst
  logic       data_ena;    // address phase on the bus
  logic       data_ena_d;  // data phase on the bus

  assign burst_idle = ~|burst_cnt;

  always_ff @(posedge HCLK_i or negedge HRESETn_i) begin
    if (!HRESETn_i) begin
      burst_cnt     <= 4'd0;
      data_ena      <= 1'b0;
      data_ena_d    <= 1'b0;
      biu_err_o     <= 1'b0;
      m_haddr_o     <= '0;
      m_hwrite_o    <= 1'b0;
      m_hsize_o     <= biu_ahb_pkg::HSIZE_WORD;
      m_hburst_o    <= biu_ahb_pkg::HBURST_SINGLE;
      m_hprot_o     <= biu_ahb_pkg::HPROT_DATA | biu_ahb_pkg::HPROT_PRIVILEGED;
      m_htrans_o    <= biu_ahb_pkg::HTRANS_IDLE;
      m_hmastlock_o <= 1'b0;
    end else begin
      biu_err_o <= 1'b0;  // single cycle pulse
      if (m_hready_i) begin
        data_ena_d <= data_ena;  // address phase moves to data phase
        if (burst_idle) begin
          if (biu_stb_ack_o) begin
            data_ena      <= 1'b1;
            burst_cnt     <= type2cnt(biu_type_i);
            m_htrans_o    <= biu_ahb_pkg::HTRANS_NONSEQ;  // first beat
            m_haddr_o     <= biu_adri_i;
            m_hwrite_o    <= biu_we_i;
            m_hsize_o     <= size2hsize(biu_size_i);
            m_hburst_o    <= type2hburst(biu_type_i);
            m_hprot_o     <= prot2hprot(biu_prot_i);
            m_hmastlock_o <= biu_lock_i;
          end else begin
            data_ena      <= 1'b0;
            m_htrans_o    <= biu_ahb_pkg::HTRANS_IDLE;
            m_hmastlock_o <= biu_lock_i;  // lock may be held over idle
          end
        end else begin
          data_ena   <= 1'b1;
          burst_cnt  <= burst_cnt - 4'd1;
          m_htrans_o <= biu_ahb_pkg::HTRANS_SEQ;
          m_haddr_o  <= nxt_addr(m_haddr_o, m_hburst_o);
        end
      end else if (m_hresp_i == biu_ahb_pkg::HRESP_ERROR) begin
        // first error cycle, drop the rest of the burst
        burst_cnt  <= 4'd0;
        data_ena   <= 1'b0;
        data_ena_d <= 1'b0;  // no ack in the second error cycle
        m_htrans_o <= biu_ahb_pkg::HTRANS_IDLE;
        biu_err_o  <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // data path

  // write data taken with its address phase, driven during the data phase
  always_ff @(posedge HCLK_i) begin
    if (biu_d_ack_o) begin
      m_hwdata_o <= biu_d_i;
    end
    if (m_hready_i) begin
      biu_adro_o <= m_haddr_o;
    end
  end

  assign biu_q_o       = hrdata_i;
  assign biu_ack_o     = m_hready_i & data_ena_d;
  assign biu_d_ack_o   = m_hready_i & data_ena;
  assign biu_stb_ack_o = m_hready_i & burst_idle & biu_stb_i & ~biu_err_o;  // none during err

endmodule

`default_nettype wire

// ==== biu_ahb_pkg.sv ====
//////////////////////////////
// biu to ahb-lite shared definitions
// bus widths, biu request codes and ahb-lite encodings
//////////////////////////////
`default_nettype none

package biu_ahb_pkg;

  //////////////////////////////
  // widths
  localparam int XLEN = 32;  // data, one word
  localparam int PLEN = 32;  // byte address

  //////////////////////////////
  // biu burst types
  localparam logic [2:0] BIU_SINGLE = 3'd0;
  localparam logic [2:0] BIU_INCR   = 3'd1;  // undefined length, one beat here
  localparam logic [2:0] BIU_WRAP4  = 3'd2;
  localparam logic [2:0] BIU_INCR4  = 3'd3;
  localparam logic [2:0] BIU_WRAP8  = 3'd4;
  localparam logic [2:0] BIU_INCR8  = 3'd5;
  localparam logic [2:0] BIU_WRAP16 = 3'd6;
  localparam logic [2:0] BIU_INCR16 = 3'd7;

  // biu transfer sizes
  localparam logic [2:0] BIU_BYTE  = 3'd0;
  localparam logic [2:0] BIU_HWORD = 3'd1;
  localparam logic [2:0] BIU_WORD  = 3'd2;

  // biu protection bits
  localparam logic [2:0] PROT_DATA       = 3'b001;  // clear for opcode fetch
  localparam logic [2:0] PROT_PRIVILEGED = 3'b010;
  localparam logic [2:0] PROT_CACHEABLE  = 3'b100;

  //////////////////////////////
  // ahb-lite encodings
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [2:0] HBURST_SINGLE = 3'd0;
  localparam logic [2:0] HBURST_INCR   = 3'd1;
  localparam logic [2:0] HBURST_WRAP4  = 3'd2;
  localparam logic [2:0] HBURST_INCR4  = 3'd3;
  localparam logic [2:0] HBURST_WRAP8  = 3'd4;
  localparam logic [2:0] HBURST_INCR8  = 3'd5;
  localparam logic [2:0] HBURST_WRAP16 = 3'd6;
  localparam logic [2:0] HBURST_INCR16 = 3'd7;

  localparam logic [2:0] HSIZE_BYTE  = 3'd0;
  localparam logic [2:0] HSIZE_HWORD = 3'd1;
  localparam logic [2:0] HSIZE_WORD  = 3'd2;

  localparam logic [3:0] HPROT_DATA       = 4'b0001;
  localparam logic [3:0] HPROT_PRIVILEGED = 4'b0010;
  localparam logic [3:0] HPROT_CACHEABLE  = 4'b1000;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  //////////////////////////////
  // arbiter ports, index doubles as grant value
  localparam int   NUM_MASTERS = 2;
  localparam logic MST_IBUS    = 1'b0;
  localparam logic MST_DBUS    = 1'b1;

endpackage

`default_nettype wire

// ==== biu_dual_ahb_top.sv ====
//////////////////////////////
// dual biu to ahb-lite subsystem
// instruction and data masters share one ahb-lite port
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module biu_dual_ahb_top (
  input  logic                         HCLK,
  input  logic                         HRESETn,
  // instruction biu
  input  logic                         ibiu_stb_i,
  output logic                         ibiu_stb_ack_o,
  output logic                         ibiu_d_ack_o,
  input  logic [biu_ahb_pkg::PLEN-1:0] ibiu_adri_i,
  output logic [biu_ahb_pkg::PLEN-1:0] ibiu_adro_o,
  input  logic [2:0]                   ibiu_size_i,
  input  logic [2:0]                   ibiu_type_i,
  input  logic [2:0]                   ibiu_prot_i,
  input  logic                         ibiu_lock_i,
  input  logic                         ibiu_we_i,
  input  logic [biu_ahb_pkg::XLEN-1:0] ibiu_d_i,
  output logic [biu_ahb_pkg::XLEN-1:0] ibiu_q_o,
  output logic                         ibiu_ack_o,
  output logic                         ibiu_err_o,
  // data biu
  input  logic                         dbiu_stb_i,
  output logic                         dbiu_stb_ack_o,
  output logic                         dbiu_d_ack_o,
  input  logic [biu_ahb_pkg::PLEN-1:0] dbiu_adri_i,
  output logic [biu_ahb_pkg::PLEN-1:0] dbiu_adro_o,
  input  logic [2:0]                   dbiu_size_i,
  input  logic [2:0]                   dbiu_type_i,
  input  logic [2:0]                   dbiu_prot_i,
  input  logic                         dbiu_lock_i,
  input  logic                         dbiu_we_i,
  input  logic [biu_ahb_pkg::XLEN-1:0] dbiu_d_i,
  output logic [biu_ahb_pkg::XLEN-1:0] dbiu_q_o,
  output logic                         dbiu_ack_o,
  output logic                         dbiu_err_o,
  // ahb-lite master port
  output logic [biu_ahb_pkg::PLEN-1:0] haddr_o,
  output logic                         hwrite_o,
  output logic [2:0]                   hsize_o,
  output logic [2:0]                   hburst_o,
  output logic [3:0]                   hprot_o,
  output logic [1:0]                   htrans_o,
  output logic                         hmastlock_o,
  output logic [biu_ahb_pkg::XLEN-1:0] hwdata_o,
  input  logic [biu_ahb_pkg::XLEN-1:0] hrdata_i,
  input  logic                         hready_i,
  input  logic                         hresp_i
);

  // per master links to the arbiter
  logic [biu_ahb_pkg::PLEN-1:0] i_haddr;
  logic [biu_ahb_pkg::PLEN-1:0] d_haddr;
  logic [biu_ahb_pkg::XLEN-1:0] i_hwdata;
  logic [biu_ahb_pkg::XLEN-1:0] d_hwdata;
  logic [2:0] i_hsize;
  logic [2:0] d_hsize;
  logic [2:0] i_hburst;
  logic [2:0] d_hburst;
  logic [3:0] i_hprot;
  logic [3:0] d_hprot;
  logic [1:0] i_htrans;
  logic [1:0] d_htrans;
  logic i_hwrite;
  logic d_hwrite;
  logic i_hmastlock;
  logic d_hmastlock;
  logic [biu_ahb_pkg::NUM_MASTERS-1:0] m_hready;  // indexed by master
  logic [biu_ahb_pkg::NUM_MASTERS-1:0] m_hresp;

  biu_ahb_master u_ibus (
    .HCLK_i(HCLK), .HRESETn_i(HRESETn),
    .biu_stb_i(ibiu_stb_i), .biu_stb_ack_o(ibiu_stb_ack_o), .biu_d_ack_o(ibiu_d_ack_o),
    .biu_adri_i(ibiu_adri_i), .biu_adro_o(ibiu_adro_o),
    .biu_size_i(ibiu_size_i), .biu_type_i(ibiu_type_i), .biu_prot_i(ibiu_prot_i),
    .biu_lock_i(ibiu_lock_i), .biu_we_i(ibiu_we_i), .biu_d_i(ibiu_d_i), .biu_q_o(ibiu_q_o),
    .biu_ack_o(ibiu_ack_o), .biu_err_o(ibiu_err_o),
    .m_haddr_o(i_haddr), .m_hwrite_o(i_hwrite), .m_hsize_o(i_hsize), .m_hburst_o(i_hburst),
    .m_hprot_o(i_hprot), .m_htrans_o(i_htrans), .m_hmastlock_o(i_hmastlock),
    .m_hwdata_o(i_hwdata),
    .m_hready_i(m_hready[biu_ahb_pkg::MST_IBUS]), .m_hresp_i(m_hresp[biu_ahb_pkg::MST_IBUS]),
    .hrdata_i(hrdata_i)
  );

  biu_ahb_master u_dbus (
    .HCLK_i(HCLK), .HRESETn_i(HRESETn),
    .biu_stb_i(dbiu_stb_i), .biu_stb_ack_o(dbiu_stb_ack_o), .biu_d_ack_o(dbiu_d_ack_o),
    .biu_adri_i(dbiu_adri_i), .biu_adro_o(dbiu_adro_o),
    .biu_size_i(dbiu_size_i), .biu_type_i(dbiu_type_i), .biu_prot_i(dbiu_prot_i),
    .biu_lock_i(dbiu_lock_i), .biu_we_i(dbiu_we_i), .biu_d_i(dbiu_d_i), .biu_q_o(dbiu_q_o),
    .biu_ack_o(dbiu_ack_o), .biu_err_o(dbiu_err_o),
    .m_haddr_o(d_haddr), .m_hwrite_o(d_hwrite), .m_hsize_o(d_hsize), .m_hburst_o(d_hburst),
    .m_hprot_o(d_hprot), .m_htrans_o(d_htrans), .m_hmastlock_o(d_hmastlock),
    .m_hwdata_o(d_hwdata),
    .m_hready_i(m_hready[biu_ahb_pkg::MST_DBUS]), .m_hresp_i(m_hresp[biu_ahb_pkg::MST_DBUS]),
    .hrdata_i(hrdata_i)
  );

  ahb_master_arbiter u_arb (
    .HCLK_i(HCLK), .HRESETn_i(HRESETn),
    .ihaddr_i(i_haddr), .ihwrite_i(i_hwrite), .ihsize_i(i_hsize), .ihburst_i(i_hburst),
    .ihprot_i(i_hprot), .ihtrans_i(i_htrans), .ihmastlock_i(i_hmastlock),
    .ihwdata_i(i_hwdata),
    .ihready_o(m_hready[biu_ahb_pkg::MST_IBUS]), .ihresp_o(m_hresp[biu_ahb_pkg::MST_IBUS]),
    .dhaddr_i(d_haddr), .dhwrite_i(d_hwrite), .dhsize_i(d_hsize), .dhburst_i(d_hburst),
    .dhprot_i(d_hprot), .dhtrans_i(d_htrans), .dhmastlock_i(d_hmastlock),
    .dhwdata_i(d_hwdata),
    .dhready_o(m_hready[biu_ahb_pkg::MST_DBUS]), .dhresp_o(m_hresp[biu_ahb_pkg::MST_DBUS]),
    .haddr_o(haddr_o), .hwrite_o(hwrite_o), .hsize_o(hsize_o), .hburst_o(hburst_o),
    .hprot_o(hprot_o), .htrans_o(htrans_o), .hmastlock_o(hmastlock_o), .hwdata_o(hwdata_o),
    .hready_i(hready_i), .hresp_i(hresp_i)
  );

endmodule

`default_nettype wire

// ==== compile.f ====
biu_ahb_pkg.sv
biu_ahb_master.sv
ahb_master_arbiter.sv
biu_dual_ahb_top.sv
ahb_mem_slave.sv
tb_biu_dual_ahb.sv

// ==== tb_biu_dual_ahb.sv ====
//////////////////////////////
// testbench for the dual biu to ahb-lite subsystem
// table driven requests on both ports, shadow memory model
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_biu_dual_ahb;

  typedef struct packed {
    logic        port;   // 0 ibus, 1 dbus
    logic        we;
    logic [2:0]  btype;
    logic [2:0]  size;
    logic [31:0] addr;
    logic [31:0] seed;   // xor into write data
    logic        err;    // err expected
    logic        par;    // runs alongside the next row
  } row_t;

  localparam int NROWS = 13;
  localparam logic IB = biu_ahb_pkg::MST_IBUS;
  localparam logic DB = biu_ahb_pkg::MST_DBUS;
  localparam logic [2:0] WD = biu_ahb_pkg::BIU_WORD;

  row_t tab [NROWS] = '{
    '{DB, 1'b1, biu_ahb_pkg::BIU_SINGLE, WD, 32'h100, 32'h0000_1111, 1'b0, 1'b0},
    '{DB, 1'b0, biu_ahb_pkg::BIU_SINGLE, WD, 32'h100, 32'h0, 1'b0, 1'b0},
    '{DB, 1'b1, biu_ahb_pkg::BIU_INCR4,  WD, 32'h040, 32'h4444_0000, 1'b0, 1'b0},
    '{DB, 1'b1, biu_ahb_pkg::BIU_INCR8,  WD, 32'h080, 32'h8888_0000, 1'b0, 1'b0},
    '{IB, 1'b0, biu_ahb_pkg::BIU_INCR4,  WD, 32'h040, 32'h0, 1'b0, 1'b0},
    '{IB, 1'b0, biu_ahb_pkg::BIU_INCR8,  WD, 32'h080, 32'h0, 1'b0, 1'b0},
    '{IB, 1'b0, biu_ahb_pkg::BIU_WRAP4,  WD, 32'h048, 32'h0, 1'b0, 1'b0},  // mid block
    '{DB, 1'b0, biu_ahb_pkg::BIU_WRAP8,  WD, 32'h08c, 32'h0, 1'b0, 1'b0},
    '{DB, 1'b1, biu_ahb_pkg::BIU_INCR4,  WD, 32'h800, 32'h0, 1'b1, 1'b0},  // fault region
    '{DB, 1'b0, biu_ahb_pkg::BIU_SINGLE, WD, 32'h100, 32'h0, 1'b0, 1'b0},
    '{DB, 1'b1, biu_ahb_pkg::BIU_INCR8,  WD, 32'h0c0, 32'hcccc_0000, 1'b0, 1'b1},
    '{IB, 1'b0, biu_ahb_pkg::BIU_INCR8,  WD, 32'h080, 32'h0, 1'b0, 1'b0},
    '{IB, 1'b0, biu_ahb_pkg::BIU_INCR8,  WD, 32'h0c0, 32'h0, 1'b0, 1'b0}
  };

  logic        HCLK;
  logic        HRESETn;
  logic        stb [2];  // biu inputs, indexed by port
  logic [31:0] adri [2];
  logic [2:0]  size [2];
  logic [2:0]  btype [2];
  logic        we [2];
  logic [31:0] d [2];
  logic        stb_ack [2];  // biu outputs
  logic        d_ack [2];
  logic        ack [2];
  logic        err [2];
  logic [31:0] adro [2];
  logic [31:0] q [2];
  logic [31:0] haddr, hwdata, hrdata;
  logic [2:0]  hsize, hburst;
  logic [3:0]  hprot;
  logic [1:0]  htrans;
  logic        hwrite, hmastlock, hready, hresp;

  logic [31:0] shadow [256];
  logic [31:0] lcg_state = 32'd13641;
  bit          open_b [2];  // port is between first and last ack

  biu_dual_ahb_top dut (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .ibiu_stb_i(stb[0]), .ibiu_stb_ack_o(stb_ack[0]), .ibiu_d_ack_o(d_ack[0]),
    .ibiu_adri_i(adri[0]), .ibiu_adro_o(adro[0]), .ibiu_size_i(size[0]),
    .ibiu_type_i(btype[0]), .ibiu_prot_i(3'b010), .ibiu_lock_i(1'b0), .ibiu_we_i(we[0]),
    .ibiu_d_i(d[0]), .ibiu_q_o(q[0]), .ibiu_ack_o(ack[0]), .ibiu_err_o(err[0]),
    .dbiu_stb_i(stb[1]), .dbiu_stb_ack_o(stb_ack[1]), .dbiu_d_ack_o(d_ack[1]),
    .dbiu_adri_i(adri[1]), .dbiu_adro_o(adro[1]), .dbiu_size_i(size[1]),
    .dbiu_type_i(btype[1]), .dbiu_prot_i(3'b011), .dbiu_lock_i(1'b0), .dbiu_we_i(we[1]),
    .dbiu_d_i(d[1]), .dbiu_q_o(q[1]), .dbiu_ack_o(ack[1]), .dbiu_err_o(err[1]),
    .haddr_o(haddr), .hwrite_o(hwrite), .hsize_o(hsize), .hburst_o(hburst), .hprot_o(hprot),
    .htrans_o(htrans), .hmastlock_o(hmastlock), .hwdata_o(hwdata),
    .hrdata_i(hrdata), .hready_i(hready), .hresp_i(hresp)
  );

  ahb_mem_slave u_mem (
    .HCLK_i(HCLK), .HRESETn_i(HRESETn), .haddr_i(haddr), .hwrite_i(hwrite),
    .htrans_i(htrans), .hwdata_i(hwdata), .hrdata_o(hrdata), .hready_o(hready),
    .hresp_o(hresp)
  );

  initial begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int num_beats(input logic [2:0] t);
    case (t)
      biu_ahb_pkg::BIU_WRAP4, biu_ahb_pkg::BIU_INCR4:   return 4;
      biu_ahb_pkg::BIU_WRAP8, biu_ahb_pkg::BIU_INCR8:   return 8;
      biu_ahb_pkg::BIU_WRAP16, biu_ahb_pkg::BIU_INCR16: return 16;
      default:                                          return 1;
    endcase
  endfunction

  // ahb burst code of the same name as the biu type
  function automatic logic [2:0] hburst_for(input logic [2:0] t);
    case (t)
      biu_ahb_pkg::BIU_INCR:   return biu_ahb_pkg::HBURST_INCR;
      biu_ahb_pkg::BIU_WRAP4:  return biu_ahb_pkg::HBURST_WRAP4;
      biu_ahb_pkg::BIU_INCR4:  return biu_ahb_pkg::HBURST_INCR4;
      biu_ahb_pkg::BIU_WRAP8:  return biu_ahb_pkg::HBURST_WRAP8;
      biu_ahb_pkg::BIU_INCR8:  return biu_ahb_pkg::HBURST_INCR8;
      biu_ahb_pkg::BIU_WRAP16: return biu_ahb_pkg::HBURST_WRAP16;
      biu_ahb_pkg::BIU_INCR16: return biu_ahb_pkg::HBURST_INCR16;
      default:                 return biu_ahb_pkg::HBURST_SINGLE;
    endcase
  endfunction

  // word steps, wrap bursts stay inside an aligned block
  function automatic logic [31:0] beat_addr(input logic [31:0] start, input logic [2:0] t,
                                            input int k);
    logic [31:0] span;
    case (t)
      biu_ahb_pkg::BIU_WRAP4:  span = 32'd16;
      biu_ahb_pkg::BIU_WRAP8:  span = 32'd32;
      biu_ahb_pkg::BIU_WRAP16: span = 32'd64;
      default:                 span = 32'd0;
    endcase
    if (span == 0) return start + 32'(4 * k);
    return (start & ~(span - 1)) | ((start + 32'(4 * k)) & (span - 1));
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Testbench failed");
      $fatal(1, "value check");
    end
  endtask

  // one request on one port, beat by beat until all acks or err
  task automatic run_req(input int r);
    row_t        rw;
    int          beats;
    int          acks;
    int          dacks;
    int          cyc;
    bit          tk;
    bit          dk;
    bit          errd;
    logic [31:0] a;
    logic [31:0] wd [16];
    logic [3:0]  prot_exp;
    string       pfx;
    rw    = tab[r];
    pfx   = rw.port ? "dbiu" : "ibiu";
    beats = num_beats(rw.btype);
    for (int k = 0; k < beats; k++) begin
      if (rw.we) wd[k] = lcg_next() ^ rw.seed;
      else wd[k] = 32'd0;  // reads draw no random data
    end
    prot_exp = biu_ahb_pkg::HPROT_PRIVILEGED;  // both ports privileged
    if (rw.port) prot_exp = prot_exp | biu_ahb_pkg::HPROT_DATA;
    acks  = 0;
    dacks = 0;
    cyc   = 0;
    errd  = 1'b0;
    @(posedge HCLK);
    stb[rw.port]   <= 1'b1;
    adri[rw.port]  <= rw.addr;
    btype[rw.port] <= rw.btype;
    size[rw.port]  <= rw.size;
    we[rw.port]    <= rw.we;
    d[rw.port]     <= wd[0];
    while (acks < beats && !errd) begin
      @(negedge HCLK);  // outputs settled here
      cyc++;
      if (cyc > 200) begin
        $display("port %s stalled, no ack or err within 200 cycles", pfx);
        $display("Testbench failed");
        $fatal(1, "timeout");
      end
      tk = stb_ack[rw.port];
      dk = d_ack[rw.port];
      if (dk) begin  // this port's address phase accepted on the shared bus
        check("haddr_o", haddr, beat_addr(rw.addr, rw.btype, dacks));
        check("htrans_o", 32'(htrans),
              32'(dacks == 0 ? biu_ahb_pkg::HTRANS_NONSEQ : biu_ahb_pkg::HTRANS_SEQ));
        check("hwrite_o", 32'(hwrite), 32'(rw.we));
        check("hsize_o", 32'(hsize), 32'(biu_ahb_pkg::HSIZE_WORD));  // word rows only
        check("hburst_o", 32'(hburst), 32'(hburst_for(rw.btype)));
        check("hprot_o", 32'(hprot), 32'(prot_exp));
        check("hmastlock_o", 32'(hmastlock), 32'd0);
      end
      if (ack[rw.port]) begin
        a = beat_addr(rw.addr, rw.btype, acks);
        check({pfx, "_adro_o"}, adro[rw.port], a);
        check("other port open mid burst", 32'(open_b[!rw.port]), 32'd0);
        if (rw.we) shadow[a[9:2]] = wd[acks];
        else check({pfx, "_q_o"}, q[rw.port], shadow[a[9:2]]);
        acks++;
        open_b[rw.port] = (acks < beats);
      end
      if (err[rw.port]) begin
        check({pfx, "_err_o"}, 32'd1, 32'(rw.err));
        errd = 1'b1;
      end
      @(posedge HCLK);
      if (tk) stb[rw.port] <= 1'b0;
      if (dk) begin
        dacks++;
        if (dacks < beats) d[rw.port] <= wd[dacks];
      end
    end
    check({pfx, "_err_o seen"}, 32'(errd), 32'(rw.err));
    if (rw.err) check({pfx, "_ack_o count"}, 32'(acks), 32'd0);
    repeat (2) begin
      @(negedge HCLK);
      check({pfx, "_ack_o stray"}, 32'(ack[rw.port]), 32'd0);
    end
  endtask

  initial begin
    HRESETn = 1'b0;
    for (int p = 0; p < 2; p++) begin
      stb[p]   = 1'b0;
      adri[p]  = 32'd0;
      size[p]  = WD;
      btype[p] = biu_ahb_pkg::BIU_SINGLE;
      we[p]    = 1'b0;
      d[p]     = 32'd0;
      open_b[p] = 1'b0;
    end
    repeat (2) @(posedge HCLK);
    HRESETn <= 1'b1;
    for (int r = 0; r < NROWS; r++) begin
      if (tab[r].par) begin
        fork
          run_req(r);
          run_req(r + 1);
        join
        r++;
      end else begin
        run_req(r);
      end
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
